// ==== hdl/pa_pkg.sv ====
/*
	Shared word types, bus source codes and ALU function codes for the
	arithmetic and address section. Bit 0 of every word is the most
	significant bit. Modules import this package inside their bodies.
*/
package pa_pkg;

	// word width of every bus and register
	localparam int WORD_BITS = 16;
	// upper half of a word, used for the AR high byte test
	localparam int BYTE_BITS = WORD_BITS / 2;

	typedef logic [0:WORD_BITS-1] word_t;
	typedef logic [0:BYTE_BITS-1] byte_t;

	// source select codes
	typedef logic [2:0] w_src_t;
	typedef logic [2:0] a_src_t;

	// ALU function code
	typedef logic [2:0] alu_fn_t;

	// W bus sources, code 7 gives zero
	localparam w_src_t W_IR  = 3'd0;
	localparam w_src_t W_KL  = 3'd1;
	localparam w_src_t W_RDT = 3'd2;
	localparam w_src_t W_KI  = 3'd3;
	localparam w_src_t W_AT  = 3'd4;
	localparam w_src_t W_AC  = 3'd5;
	localparam w_src_t W_A   = 3'd6;

	// A bus sources, unused codes give zero
	localparam a_src_t A_ZERO = 3'd0;
	localparam a_src_t A_AR   = 3'd1;
	localparam a_src_t A_IC   = 3'd2;
	localparam a_src_t A_IR   = 3'd3;
	localparam a_src_t A_L    = 3'd4;

	// ALU functions
	// add and subtract both take cin, subtract is AC + ~A + cin
	localparam alu_fn_t FN_ADD     = 3'd0;
	localparam alu_fn_t FN_SUB     = 3'd1;
	localparam alu_fn_t FN_AND     = 3'd2;
	localparam alu_fn_t FN_OR      = 3'd3;
	localparam alu_fn_t FN_XOR     = 3'd4;
	localparam alu_fn_t FN_PASS_A  = 3'd5;
	localparam alu_fn_t FN_NOT_A   = 3'd6;
	localparam alu_fn_t FN_PASS_AC = 3'd7;

endpackage

// ==== hdl/alu.sv ====
/*
	16-bit ALU between the accumulator and the A bus.
	Purely combinational; the function code picks the operation and
	carry and overflow are only meaningful for add and subtract.
*/
`timescale 1ns/1ps

module alu (
	input  pa_pkg::word_t   a,
	input  pa_pkg::word_t   ac,
	input  pa_pkg::alu_fn_t fn,
	input  logic            cin,
	output pa_pkg::word_t   f,
	output logic            carry,
	output logic            ovf,
	output logic            zs
);

	import pa_pkg::*;

	// second adder operand, inverted for subtraction
	word_t b;
	// carry out sits in front of the 16 sum bits
	logic [0:WORD_BITS] sum;
	logic arith;

	assign arith = (fn == FN_ADD) || (fn == FN_SUB);
	assign b = (fn == FN_SUB) ? ~a : a;

	// carry ripples toward bit 0, the MSB
	assign sum = {1'b0, ac} + {1'b0, b} + {{WORD_BITS{1'b0}}, cin};

	always_comb begin
		case (fn)
			FN_ADD: begin
				f = sum[1:WORD_BITS];
			end
			FN_SUB: begin
				f = sum[1:WORD_BITS];
			end
			FN_AND: begin
				f = ac & a;
			end
			FN_OR: begin
				f = ac | a;
			end
			FN_XOR: begin
				f = ac ^ a;
			end
			FN_PASS_A: begin
				f = a;
			end
			FN_NOT_A: begin
				f = ~a;
			end
			FN_PASS_AC: begin
				f = ac;
			end
			default: begin
				f = ac;
			end
		endcase
	end

	// carry out of bit 0
	assign carry = arith & sum[0];

	// operands agree in sign but the result does not
	assign ovf = arith & (ac[0] == b[0]) & (sum[1] != ac[0]);

	assign zs = (f == '0);

endmodule

// ==== hdl/acc_path.sv ====
/*
	Accumulator path: AC and AT registers, the AT right shifter and the
	zero-flag flip-flop wzi, around the ALU. Registers change on the
	clock edge when their gated strobe is high in that cycle.
*/
`timescale 1ns/1ps

module acc_path (
	input  logic            __clk,
	input  logic            reset,
	input  pa_pkg::word_t   w,
	input  pa_pkg::word_t   a,
	input  pa_pkg::alu_fn_t alu_fn,
	input  logic            cin,
	input  logic            strob1,
	input  logic            strob2,
	input  logic            as2,
	input  logic            w_ac,
	input  logic            at_ld,
	input  logic            at_sh,
	input  logic            eat0,
	output pa_pkg::word_t   ac,
	output pa_pkg::word_t   at,
	output logic            s0,
	output logic            carry,
	output logic            ovf,
	output logic            zs,
	output logic            at15,
	output logic            wzi
);

	import pa_pkg::*;

	word_t f;
	logic stroba;
	logic strobb;
	logic ac_ld;

	// as2 picks which strobe is live
	assign stroba = ~as2 & strob1;
	assign strobb = as2 & strob2;

	assign ac_ld = w_ac & (stroba | strobb);

	alu u_alu (
		.a     (a),
		.ac    (ac),
		.fn    (alu_fn),
		.cin   (cin),
		.f     (f),
		.carry (carry),
		.ovf   (ovf),
		.zs    (zs)
	);

	always_ff @(posedge __clk) begin
		if (reset) begin
			ac <= '0;
		end else if (ac_ld) begin
			ac <= w;
		end
	end

	// load beats shift, both on strob1
	always_ff @(posedge __clk) begin
		if (reset) begin
			at <= '0;
		end else if (at_ld & strob1) begin
			at <= f;
		end else if (at_sh & strob1) begin
			at <= {eat0, at[0:WORD_BITS-2]};
		end
	end

	// zero flag sampled in the second half of the cycle
	always_ff @(posedge __clk) begin
		if (reset) begin
			wzi <= 1'b0;
		end else if (as2 & strob1) begin
			wzi <= zs;
		end
	end

	assign s0 = f[0];
	assign at15 = at[WORD_BITS-1];

endmodule

// ==== hdl/addr_path.sv ====
/*
	Address path: the AR register with load and increment and the IC
	instruction counter with clear, load and increment.
	arz flags a nonzero upper byte of AR.
*/
`timescale 1ns/1ps

module addr_path (
	input  logic          __clk,
	input  logic          reset,
	input  pa_pkg::word_t w,
	input  logic          strob1,
	input  logic          strob2,
	input  logic          as2,
	input  logic          w_ar,
	input  logic          arp1,
	input  logic          w_ic,
	input  logic          icp1,
	input  logic          off,
	output pa_pkg::word_t ar,
	output pa_pkg::word_t ic,
	output logic          arz
);

	import pa_pkg::*;

	logic stroba;
	logic strobb;
	logic ar_ld;
	logic ar_inc;
	logic ic_ld;
	logic ic_inc;
	byte_t ar_hi;

	assign stroba = ~as2 & strob1;
	assign strobb = as2 & strob2;

	assign ar_ld = w_ar & (stroba | strobb);
	// increment only on the first strobe
	assign ar_inc = arp1 & stroba;

	assign ic_ld = w_ic & (stroba | strobb);
	assign ic_inc = icp1 & strob1;

	always_ff @(posedge __clk) begin
		if (reset) begin
			ar <= '0;
		end else if (ar_ld) begin
			ar <= w;
		end else if (ar_inc) begin
			ar <= ar + word_t'(1);
		end
	end

	// off clears the counter ahead of any load
	always_ff @(posedge __clk) begin
		if (reset) begin
			ic <= '0;
		end else if (off) begin
			ic <= '0;
		end else if (ic_ld) begin
			ic <= w;
		end else if (ic_inc) begin
			ic <= ic + word_t'(1);
		end
	end

	assign ar_hi = ar[0:BYTE_BITS-1];
	assign arz = |ar_hi;

endmodule

// ==== hdl/bus_a.sv ====
/*
	A bus combiner. Selects the A bus source, forms the memory address
	dad from the gated AR and IC, and compares it with the keys for
	the address-match signal zga.
*/
`timescale 1ns/1ps

module bus_a (
	input  pa_pkg::word_t  ar,
	input  pa_pkg::word_t  ic,
	input  pa_pkg::word_t  ir,
	input  pa_pkg::word_t  l,
	input  pa_pkg::word_t  kl,
	input  pa_pkg::a_src_t a_sel,
	input  logic           ar_ad,
	input  logic           ic_ad,
	input  logic           barnb,
	output pa_pkg::word_t  a,
	output pa_pkg::word_t  dad,
	output logic           zga
);

	import pa_pkg::*;

	// the compare word has its top bit taken from the block select
	word_t match_word;

	always_comb begin
		case (a_sel)
			A_ZERO: begin
				a = '0;
			end
			A_AR: begin
				a = ar;
			end
			A_IC: begin
				a = ic;
			end
			A_IR: begin
				a = ir;
			end
			A_L: begin
				a = l;
			end
			default: begin
				a = '0;
			end
		endcase
	end

	// both gates open gives the OR of the two
	assign dad = ({WORD_BITS{ar_ad}} & ar) | ({WORD_BITS{ic_ad}} & ic);

	assign match_word = {~barnb, dad[1:WORD_BITS-1]};
	assign zga = (kl == match_word);

endmodule

// ==== hdl/bus_w.sv ====
/*
	W bus combiner. Selects one of the register and input words onto
	the W bus and drives the memory data output ddt from it while
	w_dt is high.
*/
`timescale 1ns/1ps

module bus_w (
	input  pa_pkg::word_t  ir,
	input  pa_pkg::word_t  kl,
	input  pa_pkg::word_t  rdt,
	input  pa_pkg::word_t  ki,
	input  pa_pkg::word_t  at,
	input  pa_pkg::word_t  ac,
	input  pa_pkg::word_t  a,
	input  pa_pkg::w_src_t w_sel,
	input  logic           w_dt,
	output pa_pkg::word_t  w,
	output pa_pkg::word_t  ddt
);

	import pa_pkg::*;

	always_comb begin
		case (w_sel)
			W_IR: begin
				w = ir;
			end
			W_KL: begin
				w = kl;
			end
			W_RDT: begin
				w = rdt;
			end
			W_KI: begin
				w = ki;
			end
			W_AT: begin
				w = at;
			end
			W_AC: begin
				w = ac;
			end
			W_A: begin
				w = a;
			end
			// code 7, nothing on the bus
			default: begin
				w = '0;
			end
		endcase
	end

	assign ddt = w & {WORD_BITS{w_dt}};

endmodule

// ==== hdl/pa.sv ====
/*
	Top of the arithmetic and address section. Wires the accumulator
	and address paths to the A and W bus combiners; holds no logic.
*/
`timescale 1ns/1ps

module pa (
	input  logic            __clk,
	input  logic            reset,
	input  pa_pkg::word_t   ir,
	input  pa_pkg::word_t   ki,
	input  pa_pkg::word_t   rdt,
	input  pa_pkg::word_t   kl,
	input  pa_pkg::word_t   l,
	input  pa_pkg::w_src_t  w_sel,
	input  pa_pkg::a_src_t  a_sel,
	input  pa_pkg::alu_fn_t alu_fn,
	input  logic            w_dt,
	input  logic            cin,
	input  logic            strob1,
	input  logic            strob2,
	input  logic            as2,
	input  logic            w_ac,
	input  logic            at_ld,
	input  logic            at_sh,
	input  logic            eat0,
	input  logic            w_ar,
	input  logic            arp1,
	input  logic            w_ic,
	input  logic            icp1,
	input  logic            off,
	input  logic            ar_ad,
	input  logic            ic_ad,
	input  logic            barnb,
	output pa_pkg::word_t   w,
	output pa_pkg::word_t   ddt,
	output pa_pkg::word_t   dad,
	output logic            s0,
	output logic            carry,
	output logic            ovf,
	output logic            zs,
	output logic            at15,
	output logic            wzi,
	output logic            arz,
	output logic            zga
);

	import pa_pkg::*;

	// register outputs and the A bus
	word_t ac;
	word_t at;
	word_t ar;
	word_t ic;
	word_t a;

	acc_path u_acc_path (
		.__clk  (__clk),
		.reset  (reset),
		.w      (w),
		.a      (a),
		.alu_fn (alu_fn),
		.cin    (cin),
		.strob1 (strob1),
		.strob2 (strob2),
		.as2    (as2),
		.w_ac   (w_ac),
		.at_ld  (at_ld),
		.at_sh  (at_sh),
		.eat0   (eat0),
		.ac     (ac),
		.at     (at),
		.s0     (s0),
		.carry  (carry),
		.ovf    (ovf),
		.zs     (zs),
		.at15   (at15),
		.wzi    (wzi)
	);

	addr_path u_addr_path (
		.__clk  (__clk),
		.reset  (reset),
		.w      (w),
		.strob1 (strob1),
		.strob2 (strob2),
		.as2    (as2),
		.w_ar   (w_ar),
		.arp1   (arp1),
		.w_ic   (w_ic),
		.icp1   (icp1),
		.off    (off),
		.ar     (ar),
		.ic     (ic),
		.arz    (arz)
	);

	// a depends only on registers and inputs, so no loop through w
	bus_a u_bus_a (
		.ar    (ar),
		.ic    (ic),
		.ir    (ir),
		.l     (l),
		.kl    (kl),
		.a_sel (a_sel),
		.ar_ad (ar_ad),
		.ic_ad (ic_ad),
		.barnb (barnb),
		.a     (a),
		.dad   (dad),
		.zga   (zga)
	);

	bus_w u_bus_w (
		.ir    (ir),
		.kl    (kl),
		.rdt   (rdt),
		.ki    (ki),
		.at    (at),
		.ac    (ac),
		.a     (a),
		.w_sel (w_sel),
		.w_dt  (w_dt),
		.w     (w),
		.ddt   (ddt)
	);

endmodule

// ==== test/tb_pa.sv ====
/*
	Testbench for the arithmetic and address section. A reference model
	tracks AC, AT, AR, IC and wzi, and every output is compared with it
	on the falling clock edge while directed and random stimulus runs.
*/
`timescale 1ns/1ps

module tb_pa;

	import pa_pkg::*;

	logic    __clk = 1'b0;
	logic    reset;
	word_t   ir;
	word_t   ki;
	word_t   rdt;
	word_t   kl;
	word_t   l;
	w_src_t  w_sel;
	a_src_t  a_sel;
	alu_fn_t alu_fn;
	logic    w_dt;
	logic    cin;
	logic    strob1;
	logic    strob2;
	logic    as2;
	logic    w_ac;
	logic    at_ld;
	logic    at_sh;
	logic    eat0;
	logic    w_ar;
	logic    arp1;
	logic    w_ic;
	logic    icp1;
	logic    off;
	logic    ar_ad;
	logic    ic_ad;
	logic    barnb;
	word_t   w;
	word_t   ddt;
	word_t   dad;
	logic    s0;
	logic    carry;
	logic    ovf;
	logic    zs;
	logic    at15;
	logic    wzi;
	logic    arz;
	logic    zga;

	// model registers
	word_t m_ac;
	word_t m_at;
	word_t m_ar;
	word_t m_ic;
	logic  m_wzi;

	// model combinational values
	word_t       exp_a;
	word_t       exp_w;
	word_t       exp_f;
	word_t       exp_dad;
	word_t       opnd;
	logic [16:0] usum;
	int          ssum;
	logic        exp_carry;
	logic        exp_ovf;
	logic        exp_zs;
	logic        strob_live;

	int errors = 0;
	int checks = 0;
	int cycles_checked = 0;

	pa dut (.*);

	always #10 __clk = ~__clk;

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge __clk);
		reset <= 1'b0;
	end

	assign strob_live = (strob1 & ~as2) | (strob2 & as2);

	always_comb begin
		case (a_sel)
			A_AR: exp_a = m_ar;
			A_IC: exp_a = m_ic;
			A_IR: exp_a = ir;
			A_L: exp_a = l;
			default: exp_a = '0;
		endcase
	end

	// overflow taken from the signed range of the true sum
	always_comb begin
		opnd = (alu_fn == FN_SUB) ? ~exp_a : exp_a;
		usum = {1'b0, m_ac} + {1'b0, opnd} + {16'd0, cin};
		ssum = int'($signed(m_ac)) + int'($signed(opnd)) + int'(cin);
		exp_carry = 1'b0;
		exp_ovf = 1'b0;
		case (alu_fn)
			FN_ADD, FN_SUB: begin
				exp_f = usum[15:0];
				exp_carry = usum[16];
				exp_ovf = (ssum > 32767) || (ssum < -32768);
			end
			FN_AND: exp_f = m_ac & exp_a;
			FN_OR: exp_f = m_ac | exp_a;
			FN_XOR: exp_f = m_ac ^ exp_a;
			FN_PASS_A: exp_f = exp_a;
			FN_NOT_A: exp_f = ~exp_a;
			default: exp_f = m_ac;
		endcase
	end

	always_comb begin
		case (w_sel)
			W_IR: exp_w = ir;
			W_KL: exp_w = kl;
			W_RDT: exp_w = rdt;
			W_KI: exp_w = ki;
			W_AT: exp_w = m_at;
			W_AC: exp_w = m_ac;
			W_A: exp_w = exp_a;
			default: exp_w = '0;
		endcase
	end

	assign exp_zs = (exp_f == '0);
	assign exp_dad = (ar_ad ? m_ar : '0) | (ic_ad ? m_ic : '0);

	always @(posedge __clk) begin
		if (reset) begin
			m_ac <= '0;
			m_at <= '0;
			m_ar <= '0;
			m_ic <= '0;
			m_wzi <= 1'b0;
		end else begin
			if (w_ac && strob_live)
				m_ac <= exp_w;
			if (strob1 && at_ld)
				m_at <= exp_f;
			else if (strob1 && at_sh)
				m_at <= {eat0, m_at[0:14]};
			if (as2 && strob1)
				m_wzi <= exp_zs;
			if (w_ar && strob_live)
				m_ar <= exp_w;
			else if (arp1 && strob1 && !as2)
				m_ar <= m_ar + 16'd1;
			if (off)
				m_ic <= '0;
			else if (w_ic && strob_live)
				m_ic <= exp_w;
			else if (icp1 && strob1)
				m_ic <= m_ic + 16'd1;
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, want);
		end
	endtask

	// outputs are stable half a cycle after the inputs change
	always @(negedge __clk) begin
		if (!reset) begin
			check_word("w", w, exp_w);
			check_word("ddt", ddt, exp_w & {16{w_dt}});
			check_word("dad", dad, exp_dad);
			check_bit("s0", s0, exp_f[0]);
			check_bit("carry", carry, exp_carry);
			check_bit("ovf", ovf, exp_ovf);
			check_bit("zs", zs, exp_zs);
			check_bit("at15", at15, m_at[15]);
			check_bit("wzi", wzi, m_wzi);
			check_bit("arz", arz, m_ar[0:7] != 8'd0);
			check_bit("zga", zga, kl == {~barnb, exp_dad[1:15]});
			cycles_checked++;
		end
	end

	function automatic word_t rand_word();
		logic [31:0] r;
		r = $urandom();
		return r[15:0];
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = $urandom();
		return r[0];
	endfunction

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	// strobes and enables drop back to idle every cycle
	task automatic next_cycle();
		@(posedge __clk);
		strob1 <= 1'b0;
		strob2 <= 1'b0;
		as2 <= 1'b0;
		w_ac <= 1'b0;
		at_ld <= 1'b0;
		at_sh <= 1'b0;
		w_ar <= 1'b0;
		arp1 <= 1'b0;
		w_ic <= 1'b0;
		icp1 <= 1'b0;
		off <= 1'b0;
	endtask

	// one stroba cycle that loads the chosen registers from ki
	task automatic load_from_ki(input word_t val, input logic to_ac,
			input logic to_ar, input logic to_ic);
		next_cycle();
		ki <= val;
		w_sel <= W_KI;
		w_ac <= to_ac;
		w_ar <= to_ar;
		w_ic <= to_ic;
		strob1 <= 1'b1;
	endtask

	task automatic wait_reset_release();
		int guard;
		guard = 0;
		while (reset && guard < 20) begin
			@(posedge __clk);
			guard++;
		end
		if (reset) begin
			errors++;
			$display("Timeout: reset was never released");
		end
	endtask

	// idle until the checker has seen two more cycles
	task automatic end_phase(input string name);
		int target;
		int guard;
		next_cycle();
		target = cycles_checked + 2;
		guard = 0;
		while (cycles_checked < target && guard < 10) begin
			@(posedge __clk);
			guard++;
		end
		if (cycles_checked < target) begin
			errors++;
			$display("Timeout: checker stalled at the end of the %s phase", name);
		end
	endtask

	initial begin
		#100000;
		errors++;
		$display("Timeout: simulation did not finish in time");
		finish_run();
	end

	initial begin
		word_t x;
		word_t match;
		word_t flip;
		logic b;
		logic [3:0] pos;

		void'($urandom(32'he2b6));
		ir = '0;
		ki = '0;
		rdt = '0;
		kl = '0;
		l = '0;
		w_sel = 3'd7;
		a_sel = A_ZERO;
		alu_fn = FN_ADD;
		{w_dt, cin, strob1, strob2, as2} = '0;
		{w_ac, at_ld, at_sh, eat0} = '0;
		{w_ar, arp1, w_ic, icp1, off} = '0;
		{ar_ad, ic_ad, barnb} = '0;
		wait_reset_release();

		// every W source with ddt closed and then open
		for (int n = 0; n < 16; n++) begin
			next_cycle();
			ir <= rand_word();
			kl <= rand_word();
			rdt <= rand_word();
			ki <= rand_word();
			l <= rand_word();
			a_sel <= A_L;
			w_sel <= 3'(n);
			w_dt <= n[3];
		end
		end_phase("W bus");

		// AC from ki, A from l, result caught in AT
		for (int fn = 0; fn < 8; fn++) begin
			for (int n = 0; n < 4; n++) begin
				x = rand_word();
				load_from_ki(x, 1'b1, 1'b0, 1'b0);
				next_cycle();
				// first pass uses A equal to AC for a zero result
				l <= (n == 0) ? x : rand_word();
				cin <= (n == 0) ? 1'b1 : rand_bit();
				a_sel <= A_L;
				alu_fn <= 3'(fn);
				at_ld <= 1'b1;
				strob1 <= 1'b1;
				next_cycle();
				w_sel <= W_AT;
			end
		end
		end_phase("ALU");

		// all combinations of as2, both strobes and w_ac
		for (int n = 0; n < 16; n++) begin
			next_cycle();
			ki <= rand_word();
			w_sel <= W_KI;
			as2 <= n[0];
			strob1 <= n[1];
			strob2 <= n[2];
			w_ac <= n[3];
			next_cycle();
			w_sel <= W_AC;
		end
		end_phase("strobe gating");

		// AR shows on dad while ar_ad is high
		ar_ad <= 1'b1;
		ic_ad <= 1'b0;
		load_from_ki(rand_word(), 1'b0, 1'b1, 1'b0);
		next_cycle();
		arp1 <= 1'b1;
		strob1 <= 1'b1;
		// strobb must not increment
		next_cycle();
		arp1 <= 1'b1;
		as2 <= 1'b1;
		strob2 <= 1'b1;
		// nor strob1 while as2 is high
		next_cycle();
		arp1 <= 1'b1;
		as2 <= 1'b1;
		strob1 <= 1'b1;
		next_cycle();
		ki <= rand_word();
		w_ar <= 1'b1;
		arp1 <= 1'b1;
		strob1 <= 1'b1;
		// carry into the upper byte raises arz
		load_from_ki(16'h00ff, 1'b0, 1'b1, 1'b0);
		next_cycle();
		arp1 <= 1'b1;
		strob1 <= 1'b1;
		next_cycle();
		ar_ad <= 1'b0;
		ic_ad <= 1'b1;
		ki <= rand_word();
		w_sel <= W_KI;
		w_ic <= 1'b1;
		as2 <= 1'b1;
		strob2 <= 1'b1;
		for (int n = 0; n < 3; n++) begin
			next_cycle();
			icp1 <= 1'b1;
			strob1 <= 1'b1;
			as2 <= n[0];
		end
		next_cycle();
		ki <= rand_word();
		w_ic <= 1'b1;
		icp1 <= 1'b1;
		strob1 <= 1'b1;
		// off beats load and increment
		next_cycle();
		off <= 1'b1;
		w_ic <= 1'b1;
		icp1 <= 1'b1;
		strob1 <= 1'b1;
		end_phase("address registers");

		next_cycle();
		l <= rand_word();
		a_sel <= A_L;
		alu_fn <= FN_PASS_A;
		at_ld <= 1'b1;
		strob1 <= 1'b1;
		for (int n = 0; n < 20; n++) begin
			next_cycle();
			w_sel <= W_AT;
			eat0 <= rand_bit();
			at_sh <= 1'b1;
			// load wins at step 10, no strobe at step 5
			at_ld <= (n == 10);
			strob1 <= (n != 5);
			l <= rand_word();
		end
		// zero result captured into wzi
		next_cycle();
		l <= '0;
		as2 <= 1'b1;
		strob1 <= 1'b1;
		next_cycle();
		l <= rand_word() | 16'h0001;
		strob1 <= 1'b1;
		next_cycle();
		as2 <= 1'b1;
		strob2 <= 1'b1;
		next_cycle();
		as2 <= 1'b1;
		strob1 <= 1'b1;
		end_phase("shift and zero flag");

		load_from_ki(rand_word(), 1'b0, 1'b1, 1'b0);
		load_from_ki(rand_word(), 1'b0, 1'b0, 1'b1);
		next_cycle();
		for (int n = 0; n < 4; n++) begin
			next_cycle();
			match = (n[0] ? m_ar : '0) | (n[1] ? m_ic : '0);
			b = rand_bit();
			match[0] = ~b;
			ar_ad <= n[0];
			ic_ad <= n[1];
			barnb <= b;
			kl <= match;
			// one flipped key bit breaks the match
			next_cycle();
			pos = 4'(rand_word());
			flip = '0;
			flip[pos] = 1'b1;
			kl <= match ^ flip;
		end
		end_phase("address output");

		finish_run();
	end

endmodule

// ==== tb.f ====
hdl/pa_pkg.sv
hdl/alu.sv
hdl/acc_path.sv
hdl/addr_path.sv
hdl/bus_a.sv
hdl/bus_w.sv
hdl/pa.sv
test/tb_pa.sv

// ==== Makefile ====
# Verilator build and run of the tb_pa testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module tb_pa -o tb_pa

# the run fails unless the pass message shows up in the output
run: compile
	@out=$$(./obj_dir/tb_pa); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
